// File: sd_cmd_phy.f
sd_cmd_pkg.sv
sd_sync.sv
sd_crc7.sv
sd_cmd_rx.sv
sd_resp_tx.sv
sd_cmd_phy.sv
tb_sd_cmd_phy.sv

// File: sd_cmd_cases.txt
# C <48-bit command frame, hex> <expected crc good flag>
# R <response type code> <136-bit response word, hex> <host start bit during response>
C 400000000095 1
R 1 1100000900ff0000000000000000000000 0
C 48000001aa87 1
R 6 08000001aaff0000000000000000000000 0
C 400000000097 0
C 770000000065 1
R 5 03aaaa0520ff0000000000000000000000 0
C 694000000077 1
R 3 3f03534453433038478011223344556600 0
C 48000001aa85 0
R 2 0700000b00ff0000000000000000000000 0
C 7a00000000fd 1
R 4 3f80ff8000ff0000000000000000000000 1
C 4100000000f9 1
R 3 3f400e00325b5900003b377f800a400000 0
R 4 3fc0ff8000ff0000000000000000000000 0

// File: tb_sd_cmd_phy.sv
// ********************
// testbench for the SD CMD line PHY
// reads sd_cmd_cases.txt from the project root
// host drives CMD on rising edges and samples responses
// on rising edges, between the falling-edge updates
// stops at the first mismatch
// ********************
`default_nettype none

module tb_sd_cmd_phy
   import sd_cmd_pkg::*;
();

   localparam int INIT_CLOCKS = 60;
   localparam int WAIT_LIMIT  = 200;

   logic       sd_clk;
   logic       reset_n;
   logic       sd_cmd_i;
   logic       sd_cmd_o;
   logic       sd_cmd_t;
   cmd_frame_t cmd_in;
   logic       cmd_in_crc_good;
   logic       cmd_in_act;
   logic       resp_act;
   resp_type_e resp_type;
   resp_word_t resp_out;
   logic       resp_done;

   integer     seed;
   integer     fd;
   cmd_frame_t last_cmd;
   logic       last_good;

   sd_cmd_phy #(.INIT_CLOCKS(INIT_CLOCKS)) dut (
      .sd_clk          (sd_clk),
      .reset_n         (reset_n),
      .sd_cmd_i        (sd_cmd_i),
      .sd_cmd_o        (sd_cmd_o),
      .sd_cmd_t        (sd_cmd_t),
      .cmd_in          (cmd_in),
      .cmd_in_crc_good (cmd_in_crc_good),
      .cmd_in_act      (cmd_in_act),
      .resp_act        (resp_act),
      .resp_type       (resp_type),
      .resp_out        (resp_out),
      .resp_done       (resp_done)
   );

   always #50 sd_clk = ~sd_clk;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic expect_value(input logic [47:0] got, input logic [47:0] want,
                               input string what);
      assert (got === want) else
         stop_with_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                     $time, what, got, want));
   endtask

   // MSB-first CRC7 over wire positions first to last
   function automatic crc7_t crc7_over(input resp_word_t word, input int first, input int last);
      crc7_t c;
      logic  fb;
      int    i;
      c = '0;
      for (i = first; i <= last; i++) begin
         fb = c[6] ^ word[RESP_LONG_LEN-1-i];
         c  = c << 1;
         if (fb) begin
            c = c ^ 7'h09;
         end
      end
      return c;
   endfunction

   task automatic idle_gap();
      int gap;
      gap = 4 + ({$random(seed)} % 8);
      repeat (gap) @(posedge sd_clk);
   endtask

   task automatic send_command(input logic [47:0] frame, input logic exp_good);
      cmd_frame_t exp;
      int         i;
      exp = frame;
      for (i = 0; i < CMD_LEN; i++) begin
         @(posedge sd_clk);
         sd_cmd_i <= frame[CMD_LEN-1-i];
         // start bit sampled at i == 1, CRC end at the last one
         if (i == 1 || i == CMD_LEN - 1) begin
            @(negedge sd_clk);
            expect_value(cmd_in_act, 1'b0, "cmd_in_act inside the frame");
         end
      end
      // stop bit edge, 47 clocks after the start bit
      @(posedge sd_clk);
      @(negedge sd_clk);
      expect_value(cmd_in, exp, "cmd_in");
      expect_value(cmd_in_crc_good, exp_good, "cmd_in_crc_good");
      expect_value(cmd_in_act, exp.transmission, "cmd_in_act");
      last_cmd  = exp;
      last_good = exp_good;
   endtask

   task automatic run_response(input resp_type_e kind, input resp_word_t word,
                               input logic collide);
      resp_word_t exp;
      resp_word_t got;
      crc7_t      crc;
      int         len;
      int         crc_pos;
      int         n;
      int         waited;
      len     = (kind == resp_r2) ? RESP_LONG_LEN : CMD_LEN;
      crc_pos = (kind == resp_r2) ? R2_CRC_LAST + 1 : CMD_CRC_SPAN;
      if (kind == resp_r2) begin
         crc = crc7_over(word, R2_CRC_FIRST, R2_CRC_LAST);
      end else if (kind == resp_r3) begin
         crc = 7'h7f;
      end else begin
         crc = crc7_over(word, 0, CMD_CRC_SPAN - 1);
      end
      exp = word;
      for (n = 0; n < 7; n++) begin
         exp[RESP_LONG_LEN-1-crc_pos-n] = crc[6-n];
      end
      exp[RESP_LONG_LEN-1-crc_pos-7] = 1'b1;
      got = '0;

      // type and word settle before the request edge
      @(posedge sd_clk);
      resp_type <= kind;
      resp_out  <= word;
      repeat (4) @(posedge sd_clk);
      resp_act <= 1'b1;

      waited = 0;
      while (sd_cmd_t !== 1'b0 && waited < WAIT_LIMIT) begin
         @(posedge sd_clk);
         waited++;
      end
      if (sd_cmd_t !== 1'b0) begin
         stop_with_failure("timed out waiting for the PHY to drive CMD");
      end
      expect_value(resp_done, 1'b0, "resp_done at the first response bit");

      n = 0;
      while (sd_cmd_t === 1'b0 && n <= RESP_LONG_LEN) begin
         if (n < RESP_LONG_LEN) begin
            got[RESP_LONG_LEN-1-n] = sd_cmd_o;
         end
         // host start bit while the card is talking
         if (collide && n == 4) begin
            sd_cmd_i <= 1'b0;
         end
         if (collide && n == 7) begin
            sd_cmd_i <= 1'b1;
         end
         n++;
         @(posedge sd_clk);
      end
      resp_act <= 1'b0;
      expect_value(n, len, "response length in bits");
      expect_value(resp_done, 1'b1, "resp_done after the response");
      expect_value(sd_cmd_t, 1'b1, "sd_cmd_t after the response");
      for (n = 0; n < len; n++) begin
         expect_value(got[RESP_LONG_LEN-1-n], exp[RESP_LONG_LEN-1-n],
                      $sformatf("response bit %0d", n));
      end

      if (collide) begin
         // long enough for a wrongly accepted frame to land
         repeat (CMD_LEN + 4) @(posedge sd_clk);
         @(negedge sd_clk);
         expect_value(cmd_in, last_cmd, "cmd_in after a start bit during a response");
         expect_value(cmd_in_act, last_cmd.transmission, "cmd_in_act after the collision");
         expect_value(cmd_in_crc_good, last_good, "cmd_in_crc_good after the collision");
      end
   endtask

   task automatic run_cases();
      logic [7:0]       tag;
      logic [47:0]      frame;
      logic [8*160-1:0] rest;
      resp_word_t       word;
      int               good;
      int               code;
      int               collide;
      int               n_read;
      int               guard;
      logic             done;
      done  = 1'b0;
      guard = 0;
      while (!done && guard < 1000) begin
         guard++;
         n_read = $fscanf(fd, " %c", tag);
         if (n_read != 1) begin
            done = 1'b1;
         end else if (tag == "#") begin
            n_read = $fgets(rest, fd);
         end else if (tag == "C") begin
            n_read = $fscanf(fd, "%h %d", frame, good);
            if (n_read != 2) begin
               stop_with_failure("a command line in the case file could not be read");
            end
            idle_gap();
            send_command(frame, good[0]);
         end else if (tag == "R") begin
            n_read = $fscanf(fd, "%d %h %d", code, word, collide);
            if (n_read != 3) begin
               stop_with_failure("a response line in the case file could not be read");
            end
            idle_gap();
            run_response(resp_type_e'(code), word, collide[0]);
         end else begin
            stop_with_failure("the case file holds a line of unknown type");
         end
      end
   endtask

   initial begin
      seed      = 5;
      sd_clk    = 1'b0;
      reset_n   = 1'b0;
      sd_cmd_i  = 1'b1;
      resp_act  = 1'b0;
      resp_type = resp_r1;
      resp_out  = '0;
      last_cmd  = '0;
      last_good = 1'b0;

      repeat (4) @(posedge sd_clk);
      reset_n <= 1'b1;
      @(negedge sd_clk);
      expect_value(sd_cmd_t, 1'b1, "sd_cmd_t after reset");
      expect_value(resp_done, 1'b0, "resp_done after reset");
      expect_value(cmd_in_act, 1'b0, "cmd_in_act after reset");
      expect_value(cmd_in_crc_good, 1'b0, "cmd_in_crc_good after reset");

      // CMD idles high through the power-up wait
      repeat (70) @(posedge sd_clk);

      fd = $fopen("sd_cmd_cases.txt", "r");
      if (fd == 0) begin
         stop_with_failure("could not open sd_cmd_cases.txt");
      end else begin
         run_cases();
         $fclose(fd);
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sd_cmd_phy.sv
// ********************
// SD card CMD line PHY, card side
// commands in on the rising edge, responses out on the falling edge
// resp_act is a level; its rising edge starts a response
// and it must drop before the next request
// ********************
`default_nettype none

module sd_cmd_phy
   import sd_cmd_pkg::*;
#(
   parameter int INIT_CLOCKS = 60
) (
   input  logic       sd_clk,
   input  logic       reset_n,
   input  logic       sd_cmd_i,
   output logic       sd_cmd_o,
   output logic       sd_cmd_t,
   output cmd_frame_t cmd_in,
   output logic       cmd_in_crc_good,
   output logic       cmd_in_act,
   input  logic       resp_act,
   input  resp_type_e resp_type,
   input  resp_word_t resp_out,
   output logic       resp_done
);

   logic       resp_start;
   logic [3:0] resp_type_sync;
   resp_type_e resp_type_s;
   logic       cmd_driving;

   // request level from the link clock domain
   sd_sync #(.WIDTH(1)) u_sync_act (
      .reset_n  (reset_n),
      .sd_clk   (sd_clk),
      .async_in (resp_act),
      .sync_out (),
      .rise     (resp_start)
   );

   sd_sync #(.WIDTH(4)) u_sync_type (
      .reset_n  (reset_n),
      .sd_clk   (sd_clk),
      .async_in (resp_type),
      .sync_out (resp_type_sync),
      .rise     ()
   );

   assign resp_type_s = resp_type_e'(resp_type_sync);

   sd_cmd_rx #(.INIT_CLOCKS(INIT_CLOCKS)) u_rx (
      .sd_clk          (sd_clk),
      .reset_n         (reset_n),
      .sd_cmd_i        (sd_cmd_i),
      .cmd_driving     (cmd_driving),
      .cmd_in          (cmd_in),
      .cmd_in_crc_good (cmd_in_crc_good),
      .cmd_in_act      (cmd_in_act)
   );

   sd_resp_tx u_tx (
      .sd_clk      (sd_clk),
      .reset_n     (reset_n),
      .start       (resp_start),
      .resp_type   (resp_type_s),
      .resp_out    (resp_out),
      .sd_cmd_o    (sd_cmd_o),
      .cmd_driving (cmd_driving),
      .resp_done   (resp_done)
   );

   // pad tristate control, high means released
   assign sd_cmd_t = ~cmd_driving;

endmodule

`default_nettype wire

// File: sd_resp_tx.sv
// ********************
// response transmitter, falling edge of sd_clk
// resp_out must be stable when start arrives
// resp_type must be synchronized along with start
// no back-pressure; a start while busy is lost
// ********************
`default_nettype none

module sd_resp_tx
   import sd_cmd_pkg::*;
(
   input  logic       sd_clk,
   input  logic       reset_n,
   input  logic       start,
   input  resp_type_e resp_type,
   input  resp_word_t resp_out,
   output logic       sd_cmd_o,
   output logic       cmd_driving,
   output logic       resp_done
);

   logic       tx_clk;
   tx_state_e  state;
   bit_count_t count;
   resp_word_t resp_latch;
   resp_type_e resp_kind;
   logic       long_frame;
   logic       writing;
   logic       in_crc;
   bit_count_t last_bit;
   bit_count_t crc_first;
   logic       crc_clear;
   logic       crc_hold;
   logic       crc_advance;
   crc7_t      crc;

   assign tx_clk = ~sd_clk;

   assign long_frame = (resp_kind == resp_r2);
   assign writing    = (state == tx_write);

   assign last_bit  = long_frame ? bit_count_t'(RESP_LONG_LEN - 1) : bit_count_t'(CMD_LEN - 1);
   assign crc_first = long_frame ? bit_count_t'(R2_CRC_LAST + 1) : bit_count_t'(CMD_CRC_SPAN);

   // CRC field and end bit come out of the CRC register
   assign in_crc = writing && (count >= crc_first);

   // R2 leaves its first byte out of the CRC
   assign crc_clear = ((state == tx_idle) && start)
                    || (writing && long_frame && (count < bit_count_t'(R2_CRC_FIRST)));
   assign crc_hold    = writing && (resp_kind == resp_r3) && !in_crc;
   assign crc_advance = writing && !in_crc;

   sd_crc7 u_crc (
      .sd_clk    (tx_clk),
      .reset_n   (reset_n),
      .clear     (crc_clear),
      .advance   (crc_advance),
      .shift_out (in_crc),
      .hold_ones (crc_hold),
      .data_bit  (resp_latch[RESP_LONG_LEN-1]),
      .crc       (crc)
   );

   always_ff @(posedge tx_clk or negedge reset_n) begin
      if (!reset_n) begin
         state       <= tx_reset;
         count       <= '0;
         sd_cmd_o    <= 1'b1;
         cmd_driving <= 1'b0;
         resp_done   <= 1'b0;
      end else begin
         case (state)
            tx_reset: begin
               resp_done   <= 1'b0;
               cmd_driving <= 1'b0;
               state       <= tx_idle;
            end
            tx_idle: begin
               if (start) begin
                  resp_done <= 1'b0;
                  state     <= tx_preamble;
               end
            end
            tx_preamble: begin
               // one idle clock before the first bit
               count <= '0;
               state <= tx_write;
            end
            tx_write: begin
               cmd_driving <= 1'b1;
               sd_cmd_o    <= in_crc ? crc[6] : resp_latch[RESP_LONG_LEN-1];
               count       <= count + 1'b1;
               if (count == last_bit) begin
                  state <= tx_write_end;
               end
            end
            tx_write_end: begin
               cmd_driving <= 1'b0;
               resp_done   <= 1'b1;
               state       <= tx_idle;
            end
            default: begin
               state <= tx_reset;
            end
         endcase
      end
   end

   always_ff @(posedge tx_clk) begin
      if ((state == tx_idle) && start) begin
         resp_latch <= resp_out;
         resp_kind  <= resp_type;
      end else if (writing) begin
         resp_latch <= {resp_latch[RESP_LONG_LEN-2:0], 1'b1};
      end
   end

endmodule

`default_nettype wire

// File: sd_cmd_rx.sv
// ********************
// CMD receiver, rising edge of sd_clk
// waits for CMD high plus INIT_CLOCKS before accepting commands
// start bits are ignored while the PHY drives CMD
// cmd_in, cmd_in_act and cmd_in_crc_good change together,
// 47 clocks after the start bit is sampled
// ********************
`default_nettype none

module sd_cmd_rx
   import sd_cmd_pkg::*;
#(
   parameter int INIT_CLOCKS = 60
) (
   input  logic       sd_clk,
   input  logic       reset_n,
   input  logic       sd_cmd_i,
   input  logic       cmd_driving,
   output cmd_frame_t cmd_in,
   output logic       cmd_in_crc_good,
   output logic       cmd_in_act
);

   rx_state_e            state;
   bit_count_t           count;
   logic                 cmd_last;
   logic [CMD_LEN-2:0]   shift_q;
   logic                 start_seen;
   logic                 crc_clear;
   logic                 crc_advance;
   crc7_t                crc;

   // high to low on CMD while we are not driving it
   assign start_seen = ~sd_cmd_i & cmd_last & ~cmd_driving;

   assign crc_clear   = (state == rx_idle) && start_seen;
   // the start bit is a zero, so it leaves the cleared register alone
   assign crc_advance = (state == rx_read) && (count < bit_count_t'(CMD_CRC_SPAN - 1));

   sd_crc7 u_crc (
      .sd_clk    (sd_clk),
      .reset_n   (reset_n),
      .clear     (crc_clear),
      .advance   (crc_advance),
      .shift_out (1'b0),
      .hold_ones (1'b0),
      .data_bit  (sd_cmd_i),
      .crc       (crc)
   );

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state           <= rx_reset;
         count           <= '0;
         cmd_last        <= 1'b1;
         cmd_in_act      <= 1'b0;
         cmd_in_crc_good <= 1'b0;
      end else begin
         cmd_last <= sd_cmd_i;
         case (state)
            rx_reset: begin
               count <= '0;
               if (sd_cmd_i) begin
                  state <= rx_init_wait;
               end
            end
            rx_init_wait: begin
               // host clocks before its first command
               count <= count + 1'b1;
               if (count == bit_count_t'(INIT_CLOCKS - 1)) begin
                  state <= rx_idle;
               end
            end
            rx_idle: begin
               if (start_seen) begin
                  cmd_in_act <= 1'b0;
                  count      <= '0;
                  state      <= rx_read;
               end
            end
            rx_read: begin
               count <= count + 1'b1;
               // last CRC bit sampled on this edge
               if (count == bit_count_t'(CMD_LEN - 3)) begin
                  state <= rx_check;
               end
            end
            rx_check: begin
               // stop bit is on the wire now
               cmd_in_crc_good <= (shift_q[6:0] == crc);
               cmd_in_act      <= shift_q[CMD_LEN-3];
               state           <= rx_idle;
            end
            default: begin
               state <= rx_reset;
            end
         endcase
      end
   end

   // free running shifter, holds bits 0 to 46 at rx_check
   always_ff @(posedge sd_clk) begin
      shift_q <= {shift_q[CMD_LEN-3:0], sd_cmd_i};
      if (state == rx_check) begin
         cmd_in <= cmd_frame_t'({shift_q, sd_cmd_i});
      end
   end

endmodule

`default_nettype wire

// File: sd_crc7.sv
// ********************
// serial CRC7, polynomial x^7 + x^3 + 1
// control priority: clear, hold_ones, shift_out, advance
// shift_out fills with ones, so the bit after the CRC is a 1
// ********************
`default_nettype none

module sd_crc7
   import sd_cmd_pkg::*;
(
   input  logic  sd_clk,
   input  logic  reset_n,
   input  logic  clear,
   input  logic  advance,
   input  logic  shift_out,
   input  logic  hold_ones,
   input  logic  data_bit,
   output crc7_t crc
);

   logic feedback;

   assign feedback = crc[6] ^ data_bit;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (hold_ones) begin
         crc <= '1;
      end else if (shift_out) begin
         // top bit goes on the wire
         crc <= {crc[5:0], 1'b1};
      end else if (advance) begin
         crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
      end
   end

endmodule

`default_nettype wire

// File: sd_sync.sv
// ********************
// three-stage synchronizer into sd_clk
// bits of a wide input are not kept coherent, so the
// source must hold them stable across the transfer
// rise is meaningful only for WIDTH of 1
// ********************
`default_nettype none

module sd_sync #(
   parameter int WIDTH = 1
) (
   input  logic             reset_n,
   input  logic             sd_clk,
   input  logic [WIDTH-1:0] async_in,
   output logic [WIDTH-1:0] sync_out,
   output logic             rise
);

   logic [WIDTH-1:0] stage1;
   logic [WIDTH-1:0] stage2;
   logic [WIDTH-1:0] stage3;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         stage1 <= '0;
         stage2 <= '0;
         stage3 <= '0;
      end else begin
         stage1 <= async_in;
         stage2 <= stage1;
         stage3 <= stage2;
      end
   end

   assign sync_out = stage3;

   // stage2 has settled here, so this pulses once per 0 to 1 edge
   assign rise = stage2[0] & ~stage3[0];

endmodule

`default_nettype wire

// File: sd_cmd_pkg.sv
// ********************
// shared types and constants for the SD CMD line PHY
// a response word is MSB first; 48-bit responses use its top 48 bits
// resp_type codes must match the link layer's encoding
// ********************
`default_nettype none

package sd_cmd_pkg;

   // frame lengths and CRC7 bounds, in wire bit positions
   localparam int CMD_LEN       = 48;
   localparam int RESP_LONG_LEN = 136;
   localparam int CMD_CRC_SPAN  = 40;
   localparam int R2_CRC_FIRST  = 8;
   localparam int R2_CRC_LAST   = 127;

   typedef logic [6:0]   crc7_t;
   typedef logic [135:0] resp_word_t;

   // position counter, wide enough for a 136-bit frame
   typedef logic [7:0]   bit_count_t;

   // one host command, first wire bit at the top
   typedef struct packed {
      logic        start;
      logic        transmission;
      logic [5:0]  index;
      logic [31:0] argument;
      crc7_t       crc;
      logic        stop;
   } cmd_frame_t;

   // only resp_r2 selects the 136-bit frame
   typedef enum logic [3:0] {
      resp_r1  = 4'd1,
      resp_r1b = 4'd2,
      resp_r2  = 4'd3,
      resp_r3  = 4'd4,
      resp_r6  = 4'd5,
      resp_r7  = 4'd6
   } resp_type_e;

   typedef enum logic [2:0] {
      rx_reset,
      rx_init_wait,
      rx_idle,
      rx_read,
      rx_check
   } rx_state_e;

   typedef enum logic [2:0] {
      tx_reset,
      tx_idle,
      tx_preamble,
      tx_write,
      tx_write_end
   } tx_state_e;

endpackage

`default_nettype wire
